// File: verilog/aead_cfg.svh
`ifndef AEAD_CFG_SVH
`define AEAD_CFG_SVH

// datapath sizes
`define AEAD_WORD_W      32
`define AEAD_BLK_WORDS   4
`define AEAD_LEN_W       16

// tweakey round constant schedule
`define AEAD_RC_W        6
`define AEAD_RC_PER_CYC  8
`define AEAD_RC_INIT     6'h01
`define AEAD_RC_FINAL    6'h1A   // last constant of a 40 round schedule

// word buffer between framer and sequencer
`define AEAD_CREDITS     4

`endif

// File: verilog/aead_pkg.sv
`default_nettype none

`include "aead_cfg.svh"

package aead_pkg;

   typedef logic [`AEAD_WORD_W-1:0] word_t;
   typedef logic [`AEAD_LEN_W-1:0]  seg_len_t;
   typedef logic [`AEAD_RC_W-1:0]   rc_t;

   // element 0 is the first constant of the cycle, in the top bits
   typedef rc_t [0:`AEAD_RC_PER_CYC-1] rc_group_t;

   typedef enum logic [3:0] {
      ENC = 4'd2
   } instr_t;

   typedef enum logic [3:0] {
      AD    = 4'd1,
      PLAIN = 4'd4
   } seg_type_t;

   typedef enum logic [7:0] {
      AD_NORMAL  = 8'd8,
      AD_FINAL   = 8'd24,
      AD_PADDED  = 8'd26,
      MSG_NORMAL = 8'd4,
      MSG_FINAL  = 8'd20,
      MSG_PADDED = 8'd21
   } domain_t;

endpackage

`default_nettype wire

// File: verilog/word_credit_if.sv
`default_nettype none

interface word_credit_if;

   logic              valid;
   aead_pkg::word_t   word;
   aead_pkg::domain_t domain;      // meaningful on word 3
   logic              last_word;   // final block of the operation
   logic              credit_ret;  // one pulse per word leaving the buffer

   modport framer (
      output valid,
      output word,
      output domain,
      output last_word,
      input  credit_ret
   );

   modport sequencer (
      input  valid,
      input  word,
      input  domain,
      input  last_word,
      output credit_ret
   );

endinterface

`default_nettype wire

// File: verilog/rc_sched_if.sv
`default_nettype none

interface rc_sched_if;

   logic                start;  // single cycle
   aead_pkg::rc_group_t group;
   logic                valid;
   logic                done;   // with the fifth group

   modport requester (
      output start,
      input  group,
      input  valid,
      input  done
   );

   modport generator (
      input  start,
      output group,
      output valid,
      output done
   );

endinterface

`default_nettype wire

// File: verilog/segment_framer.sv
`default_nettype none

`include "aead_cfg.svh"

module segment_framer (
   input  logic            clk,
   input  logic            rst,
   input  aead_pkg::word_t pdi_data,
   input  logic            pdi_valid,
   output logic            pdi_ready,
   word_credit_if.framer   out
);

   localparam int cred_w = $clog2(`AEAD_CREDITS + 1);

   typedef enum logic [1:0] {
      st_instr,
      st_ad_hdr,
      st_msg_hdr,
      st_data
   } state_t;

   state_t              state;
   aead_pkg::seg_len_t  rem;        // bytes left at start of current block
   aead_pkg::seg_len_t  word_off;
   logic [1:0]          widx;
   logic                seg_last;
   logic                is_msg;
   logic [cred_w-1:0]   credits;

   logic                has_credit;
   logic                need_input;
   logic                partial;
   logic                seg_end;
   logic                blk_end;
   logic                issue;
   logic [3:0]          hdr_type;
   logic                hdr_last;
   aead_pkg::seg_len_t  hdr_len;
   logic                hdr_ok;
   logic                hdr_plain;

   assign hdr_type  = pdi_data[31:28];
   assign hdr_last  = pdi_data[25];
   assign hdr_len   = pdi_data[15:0];
   assign hdr_plain = (hdr_type == aead_pkg::PLAIN);
   assign hdr_ok    = hdr_plain || (hdr_type == aead_pkg::AD && state == st_ad_hdr);

   assign has_credit = (credits != '0);
   assign word_off   = aead_pkg::seg_len_t'({widx, 2'b00});
   assign need_input = (rem > word_off);
   assign partial    = (rem < 16);       // also covers an empty last segment
   assign seg_end    = (rem <= 16);
   assign blk_end    = (widx == 2'(`AEAD_BLK_WORDS - 1));
   assign issue      = (state == st_data) && has_credit && (!need_input || pdi_valid);

   always_comb begin
      if (state == st_data) begin
         pdi_ready = need_input && has_credit;
      end else begin
         pdi_ready = 1'b1;   // headers and instruction never stall
      end
   end

   always_comb begin
      out.word = need_input ? pdi_data : '0;
      if (blk_end && partial) begin
         out.word[3:0] = rem[3:0];   // pad length in last nibble
      end
   end

   always_comb begin
      if (partial) begin
         out.domain = is_msg ? aead_pkg::MSG_PADDED : aead_pkg::AD_PADDED;
      end else if (seg_end && seg_last) begin
         out.domain = is_msg ? aead_pkg::MSG_FINAL : aead_pkg::AD_FINAL;
      end else begin
         out.domain = is_msg ? aead_pkg::MSG_NORMAL : aead_pkg::AD_NORMAL;
      end
   end

   assign out.valid     = issue;
   assign out.last_word = blk_end && is_msg && seg_last && seg_end;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= st_instr;
         rem      <= '0;
         widx     <= '0;
         seg_last <= 1'b0;
         is_msg   <= 1'b0;
         credits  <= cred_w'(`AEAD_CREDITS);
      end else begin
         credits <= credits + cred_w'(out.credit_ret) - cred_w'(issue);
         case (state)
            st_instr: begin
               if (pdi_valid && hdr_type == aead_pkg::ENC) begin
                  state <= st_ad_hdr;
               end
            end
            st_ad_hdr, st_msg_hdr: begin
               if (pdi_valid && hdr_ok) begin
                  is_msg   <= hdr_plain;
                  rem      <= hdr_len;
                  seg_last <= hdr_last;
                  widx     <= '0;
                  if (hdr_len != '0 || hdr_last) begin
                     state <= st_data;
                  end else begin
                     state <= hdr_plain ? st_msg_hdr : st_ad_hdr;   // empty middle segment
                  end
               end
            end
            st_data: begin
               if (issue) begin
                  widx <= widx + 2'd1;
                  if (blk_end) begin
                     if (!seg_end) begin
                        rem <= rem - aead_pkg::seg_len_t'(16);
                     end else if (!seg_last) begin
                        state <= is_msg ? st_msg_hdr : st_ad_hdr;
                     end else begin
                        state <= is_msg ? st_instr : st_msg_hdr;
                     end
                  end
               end
            end
            default: state <= st_instr;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/round_const_gen.sv
`default_nettype none

`include "aead_cfg.svh"

module round_const_gen (
   input  logic           clk,
   input  logic           rst,
   rc_sched_if.generator  sched
);

   aead_pkg::rc_t       seed;   // first constant of the current group
   aead_pkg::rc_group_t grp;
   logic                running;

   function automatic aead_pkg::rc_t lfsr_step(input aead_pkg::rc_t c);
      return {c[4:0], c[5] ^ c[4] ^ 1'b1};
   endfunction

   // eight steps unrolled per cycle
   always_comb begin
      grp[0] = seed;
      for (int i = 1; i < `AEAD_RC_PER_CYC; i++) begin
         grp[i] = lfsr_step(grp[i-1]);
      end
   end

   assign sched.group = grp;
   assign sched.valid = running;
   assign sched.done  = running && (grp[`AEAD_RC_PER_CYC-1] == `AEAD_RC_FINAL);

   always_ff @(posedge clk) begin
      if (rst) begin
         running <= 1'b0;
      end else if (sched.start) begin
         running <= 1'b1;
      end else if (sched.done) begin
         running <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (sched.start) begin
         seed <= `AEAD_RC_INIT;
      end else if (running) begin
         seed <= lfsr_step(grp[`AEAD_RC_PER_CYC-1]);   // continue after eighth
      end
   end

endmodule

`default_nettype wire

// File: verilog/block_sequencer.sv
`default_nettype none

`include "aead_cfg.svh"

module block_sequencer #(
   parameter int n_credits = `AEAD_CREDITS
) (
   input  logic              clk,
   input  logic              rst,
   word_credit_if.sequencer  in,
   rc_sched_if.requester     sched,
   output aead_pkg::word_t   blk_data,
   output aead_pkg::domain_t blk_domain,
   output logic              blk_last,
   output logic              blk_valid,
   input  logic              blk_ready,
   output logic              op_done
);

   localparam int ptr_w = (n_credits > 1) ? $clog2(n_credits) : 1;
   localparam int cnt_w = $clog2(n_credits + 1);

   aead_pkg::word_t   mem_word [n_credits];
   aead_pkg::domain_t mem_dom  [n_credits];
   logic              mem_last [n_credits];

   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic [cnt_w-1:0]  count;
   logic [1:0]        out_idx;
   logic              hold;        // schedule of previous block running
   logic              last_pend;
   logic              start_q;
   logic              accept;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(n_credits - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (in.valid) begin
         mem_word[wr_ptr] <= in.word;
         mem_dom[wr_ptr]  <= in.domain;
         mem_last[wr_ptr] <= in.last_word;
      end
   end

   assign blk_valid     = (count != '0) && !hold;
   assign blk_data      = mem_word[rd_ptr];
   assign blk_domain    = mem_dom[rd_ptr];
   assign blk_last      = mem_last[rd_ptr];
   assign accept        = blk_valid && blk_ready;
   assign in.credit_ret = accept;
   assign sched.start   = start_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_idx   <= '0;
         hold      <= 1'b0;
         last_pend <= 1'b0;
         start_q   <= 1'b0;
         op_done   <= 1'b0;
      end else begin
         start_q <= 1'b0;
         op_done <= 1'b0;
         count   <= count + cnt_w'(in.valid) - cnt_w'(accept);
         if (in.valid) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (accept) begin
            rd_ptr  <= ptr_inc(rd_ptr);
            out_idx <= out_idx + 2'd1;
            if (out_idx == 2'(`AEAD_BLK_WORDS - 1)) begin
               hold      <= 1'b1;
               start_q   <= 1'b1;
               last_pend <= blk_last;
            end
         end
         if (sched.done) begin
            hold      <= 1'b0;
            op_done   <= last_pend;
            last_pend <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/aead_block_ctrl.sv
`default_nettype none

module aead_block_ctrl (
   input  logic                clk,
   input  logic                rst,
   input  aead_pkg::word_t     pdi_data,
   input  logic                pdi_valid,
   output logic                pdi_ready,
   output aead_pkg::word_t     blk_data,
   output aead_pkg::domain_t   blk_domain,
   output logic                blk_last,
   output logic                blk_valid,
   input  logic                blk_ready,
   output aead_pkg::rc_group_t rc_group,
   output logic                rc_valid,
   output logic                op_done
);

   word_credit_if wc_if ();
   rc_sched_if    rc_if ();

   segment_framer segment_framer_i (
      .clk       (clk),
      .rst       (rst),
      .pdi_data  (pdi_data),
      .pdi_valid (pdi_valid),
      .pdi_ready (pdi_ready),
      .out       (wc_if.framer)
   );

   round_const_gen round_const_gen_i (
      .clk   (clk),
      .rst   (rst),
      .sched (rc_if.generator)
   );

   block_sequencer block_sequencer_i (
      .clk        (clk),
      .rst        (rst),
      .in         (wc_if.sequencer),
      .sched      (rc_if.requester),
      .blk_data   (blk_data),
      .blk_domain (blk_domain),
      .blk_last   (blk_last),
      .blk_valid  (blk_valid),
      .blk_ready  (blk_ready),
      .op_done    (op_done)
   );

   assign rc_group = rc_if.group;   // no back-pressure on the schedule
   assign rc_valid = rc_if.valid;

endmodule

`default_nettype wire

// File: dv/aead_block_ctrl_chk.sv
`default_nettype none

module aead_block_ctrl_chk (
   input logic              clk,
   input logic              rst,
   input aead_pkg::word_t   blk_data,
   input aead_pkg::domain_t blk_domain,
   input logic              blk_valid,
   input logic              blk_ready,
   input logic              rc_valid,
   input logic              op_done
);
   timeunit 1ns;
   timeprecision 1ps;

   int         fails = 0;
   logic [2:0] run_len;   // rc_valid cycles so far in this run

   always_ff @(posedge clk) begin
      if (rst || !rc_valid) begin
         run_len <= '0;
      end else begin
         run_len <= run_len + 3'd1;
      end
   end

   no_overlap: assert property (@(posedge clk) disable iff (rst)
      !(blk_valid && rc_valid))
      else begin
         $error("block output and schedule active together");
         fails++;
      end

   hold_stable: assert property (@(posedge clk) disable iff (rst)
      blk_valid && !blk_ready |=> blk_valid && $stable(blk_data) && $stable(blk_domain))
      else begin
         $error("block output changed under back-pressure");
         fails++;
      end

   run_not_long: assert property (@(posedge clk) disable iff (rst)
      rc_valid |-> run_len < 3'd5)
      else begin
         $error("schedule longer than five groups");
         fails++;
      end

   run_not_short: assert property (@(posedge clk) disable iff (rst)
      !rc_valid && run_len != '0 |-> run_len == 3'd5)
      else begin
         $error("schedule shorter than five groups");
         fails++;
      end

   done_after_sched: assert property (@(posedge clk) disable iff (rst)
      op_done |-> $past(rc_valid))
      else begin
         $error("op_done without a preceding schedule group");
         fails++;
      end

endmodule

bind aead_block_ctrl aead_block_ctrl_chk chk_i (
   .clk        (clk),
   .rst        (rst),
   .blk_data   (blk_data),
   .blk_domain (blk_domain),
   .blk_valid  (blk_valid),
   .blk_ready  (blk_ready),
   .rc_valid   (rc_valid),
   .op_done    (op_done)
);

`default_nettype wire

// File: dv/tb_aead_block_ctrl.sv
`default_nettype none

`include "aead_cfg.svh"

module tb_aead_block_ctrl;
   timeunit 1ns;
   timeprecision 1ps;

   logic                clk = 1'b0;
   logic                rst = 1'b1;
   aead_pkg::word_t     pdi_data = '0;
   logic                pdi_valid = 1'b0;
   logic                pdi_ready;
   aead_pkg::word_t     blk_data;
   aead_pkg::domain_t   blk_domain;
   logic                blk_last;
   logic                blk_valid;
   logic                blk_ready = 1'b1;
   aead_pkg::rc_group_t rc_group;
   logic                rc_valid;
   logic                op_done;

   integer seed = 22267;
   int     errors = 0;
   int     timeouts = 0;
   int     done_cnt = 0;
   logic   rand_ready = 1'b0;

   aead_pkg::word_t     exp_data[$];
   aead_pkg::word_t     got_data[$];
   aead_pkg::domain_t   exp_dom[$];   // one per block
   aead_pkg::domain_t   got_dom[$];
   logic                exp_last[$];
   logic                got_last[$];
   aead_pkg::rc_group_t exp_grp[$];
   aead_pkg::rc_group_t got_grp[$];

   aead_block_ctrl aead_block_ctrl_i (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      #1;
      blk_ready = rand_ready ? 1'($random(seed)) : 1'b1;
   end

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst && blk_valid && blk_ready) begin
         got_data.push_back(blk_data);
         got_dom.push_back(blk_domain);
         got_last.push_back(blk_last);
      end
      if (!rst && rc_valid) begin
         got_grp.push_back(rc_group);
      end
      if (!rst && op_done) begin
         done_cnt++;
      end
   end

   task automatic compare_word(input string name, input aead_pkg::word_t got,
                               input aead_pkg::word_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic compare_domain(input string name, input aead_pkg::domain_t got,
                                 input aead_pkg::domain_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic compare_group(input string name, input aead_pkg::rc_group_t got,
                                input aead_pkg::rc_group_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic report_totals();
      $display("check errors %0d, assertion failures %0d, timeouts %0d",
               errors, aead_block_ctrl_i.chk_i.fails, timeouts);
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout while waiting for %s", what);
   endtask

   function automatic aead_pkg::rc_t next_const(input aead_pkg::rc_t c);
      logic fb;
      fb = ~(c[5] ^ c[4]);
      return {c[4:0], fb};
   endfunction

   task automatic expect_schedule();
      aead_pkg::rc_group_t g;
      aead_pkg::rc_t       c;
      c = `AEAD_RC_INIT;
      for (int n = 0; n < 5; n++) begin
         for (int i = 0; i < `AEAD_RC_PER_CYC; i++) begin
            g[i] = c;
            c = next_const(c);
         end
         exp_grp.push_back(g);
      end
   endtask

   // called 1 ns after a rising edge, returns at the same point
   task automatic send_word(input aead_pkg::word_t w);
      int t;
      t = 0;
      pdi_data  = w;
      pdi_valid = 1'b1;
      @(negedge clk);
      while (!pdi_ready) begin
         t++;
         if (t > 200) begin
            report_timeout("pdi_ready");
            break;
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      pdi_valid = 1'b0;
   endtask

   task automatic send_segment(input logic is_msg, input int len, input logic last);
      aead_pkg::word_t     words[$];
      aead_pkg::word_t     w;
      aead_pkg::seg_type_t t;
      int                  rem;
      int                  k;
      t = is_msg ? aead_pkg::PLAIN : aead_pkg::AD;
      for (int i = 0; i < (len + 3) / 4; i++) begin
         words.push_back($random(seed));
      end
      rem = len;
      k = 0;
      do begin
         for (int i = 0; i < `AEAD_BLK_WORDS; i++) begin
            w = '0;
            if (rem > 4 * i) begin
               w = words[k];
               k++;
            end
            if (i == 3 && rem < 16) begin
               w[3:0] = 4'(rem);   // pad length nibble
            end
            exp_data.push_back(w);
            exp_last.push_back(i == 3 && is_msg && last && rem <= 16);
         end
         if (rem < 16) begin
            exp_dom.push_back(is_msg ? aead_pkg::MSG_PADDED : aead_pkg::AD_PADDED);
         end else if (rem == 16 && last) begin
            exp_dom.push_back(is_msg ? aead_pkg::MSG_FINAL : aead_pkg::AD_FINAL);
         end else begin
            exp_dom.push_back(is_msg ? aead_pkg::MSG_NORMAL : aead_pkg::AD_NORMAL);
         end
         expect_schedule();
         rem -= 16;
      end while (rem > 0);
      send_word({t, 2'b00, last, 9'd0, 16'(len)});
      foreach (words[i]) begin
         send_word(words[i]);
      end
   endtask

   task automatic send_instr();
      send_word({aead_pkg::ENC, 28'd0});
   endtask

   task automatic wait_op_done();
      int t;
      t = 0;
      while (done_cnt == 0) begin
         t++;
         if (t > 2000) begin
            report_timeout("op_done");
            break;
         end
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic check_results();
      compare_word("word count", got_data.size(), exp_data.size());
      compare_word("group count", got_grp.size(), exp_grp.size());
      compare_word("op_done pulses", done_cnt, 1);
      foreach (exp_data[i]) begin
         if (i < got_data.size()) begin
            compare_word("blk_data", got_data[i], exp_data[i]);
            compare_bit("blk_last", got_last[i], exp_last[i]);
            if (i % 4 == 3) begin
               compare_domain("blk_domain", got_dom[i], exp_dom[i / 4]);
            end
         end
      end
      foreach (exp_grp[i]) begin
         if (i < got_grp.size()) begin
            compare_group("rc_group", got_grp[i], exp_grp[i]);
            if (i % 5 == 4) begin
               compare_word("rc_final", 32'(got_grp[i][7]), 32'(`AEAD_RC_FINAL));
            end
         end
      end
      exp_data.delete();
      got_data.delete();
      exp_dom.delete();
      got_dom.delete();
      exp_last.delete();
      got_last.delete();
      exp_grp.delete();
      got_grp.delete();
      done_cnt = 0;
   endtask

   task automatic after_reset();
      compare_bit("blk_valid", blk_valid, 1'b0);
      compare_bit("rc_valid", rc_valid, 1'b0);
      compare_bit("op_done", op_done, 1'b0);
      compare_bit("pdi_ready", pdi_ready, 1'b1);
   endtask

   task automatic full_blocks();
      send_instr();
      send_segment(1'b0, 32, 1'b1);
      send_segment(1'b1, 16, 1'b1);
      wait_op_done();
      check_results();
   endtask

   task automatic padded_blocks();
      send_instr();
      send_segment(1'b0, 7, 1'b1);
      send_segment(1'b1, 13, 1'b1);
      wait_op_done();
      check_results();
   endtask

   task automatic empty_segments();
      send_instr();
      send_segment(1'b0, 0, 1'b1);
      send_segment(1'b1, 0, 1'b1);
      wait_op_done();
      check_results();
   endtask

   task automatic split_ad_with_stalls();
      rand_ready = 1'b1;
      send_instr();
      send_segment(1'b0, 16, 1'b0);
      send_segment(1'b0, 16, 1'b0);
      send_segment(1'b0, 5, 1'b1);
      send_segment(1'b1, 20, 1'b1);
      wait_op_done();
      rand_ready = 1'b0;
      check_results();
   endtask

   initial begin
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      after_reset();
      full_blocks();
      padded_blocks();
      empty_segments();
      split_ad_with_stalls();
      report_totals();
      if (errors == 0 && timeouts == 0 && aead_block_ctrl_i.chk_i.fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/aead_pkg.sv
verilog/word_credit_if.sv
verilog/rc_sched_if.sv
verilog/segment_framer.sv
verilog/round_const_gen.sv
verilog/block_sequencer.sv
verilog/aead_block_ctrl.sv
dv/aead_block_ctrl_chk.sv
dv/tb_aead_block_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aead_block_ctrl
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SRCS := $(filter-out +%,$(shell cat tb.f))
HDRS := $(wildcard verilog/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) tb.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'TB PASSED' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
